// File: verilog/replay_pkg.sv
/*
 * Shared widths, register map, command codes and play states of the replay
 * block. The buffer holds DEPTH words. Counts are one bit wider than a
 * buffer address so that a completely full buffer can be expressed.
 */
package replay_pkg;

  // Data path and buffer geometry
  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 10;
  localparam int DEPTH      = 1 << ADDR_W;
  localparam int COUNT_W    = ADDR_W + 1;

  // Register port geometry
  localparam int REG_ADDR_W = 4;
  localparam int REG_W      = 32;
  localparam int CMD_W      = 2;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [COUNT_W-1:0]    count_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_W-1:0]      reg_data_t;

  //------------------------------------------------------------------------
  // Register map
  //------------------------------------------------------------------------
  localparam reg_addr_t REG_REC_SIZE     = 4'd0;
  localparam reg_addr_t REG_REC_FULLNESS = 4'd1;
  localparam reg_addr_t REG_REC_RESTART  = 4'd2;
  localparam reg_addr_t REG_PLAY_BASE    = 4'd3;
  localparam reg_addr_t REG_PLAY_WORDS   = 4'd4;
  localparam reg_addr_t REG_PLAY_CMD     = 4'd5;
  // Bit 0 reads back as playing
  localparam reg_addr_t REG_STATUS       = 4'd6;

  // Play commands, low bits of a PLAY_CMD write
  localparam logic [CMD_W-1:0] CMD_STOP = 2'd0;
  localparam logic [CMD_W-1:0] CMD_ONCE = 2'd1;
  localparam logic [CMD_W-1:0] CMD_CONT = 2'd2;

  typedef enum logic [1:0] {
    PLAY_IDLE,
    PLAY_ONCE,
    PLAY_CONT
  } play_state_t;

endpackage

// File: verilog/replay_regs.sv
`timescale 1ns/1ps

/*
 * Register port of the replay block. One request at a time; the ack and the
 * read data follow one cycle after the request. Unknown addresses read as
 * zero. REC_SIZE saturates at the buffer depth on write.
 */
module replay_regs (
  input  logic                         mem_clk,
  input  logic                         i_rst_n,
  input  logic                         i_ctrl_req_wr,
  input  logic                         i_ctrl_req_rd,
  input  replay_pkg::reg_addr_t        i_ctrl_req_addr,
  input  replay_pkg::reg_data_t        i_ctrl_req_data,
  input  replay_pkg::count_t           i_rec_fullness,
  input  logic                         i_playing,
  output logic                         o_ctrl_resp_ack,
  output replay_pkg::reg_data_t        o_ctrl_resp_data,
  output replay_pkg::count_t           o_rec_size,
  output logic                         o_rec_restart,
  output replay_pkg::addr_t            o_play_base,
  output replay_pkg::count_t           o_play_words,
  output logic                         o_play_cmd_valid,
  output logic [replay_pkg::CMD_W-1:0] o_play_cmd
);
  import replay_pkg::*;

  reg_data_t rd_mux;
  count_t    size_wr;
  logic      wr_hit_restart;
  logic      wr_hit_cmd;

  // Strobe registers
  assign wr_hit_restart = i_ctrl_req_wr && (i_ctrl_req_addr == REG_REC_RESTART);
  assign wr_hit_cmd     = i_ctrl_req_wr && (i_ctrl_req_addr == REG_PLAY_CMD);

  // Record size never exceeds the buffer
  assign size_wr = (i_ctrl_req_data > REG_W'(DEPTH)) ? COUNT_W'(DEPTH) :
                   i_ctrl_req_data[COUNT_W-1:0];

  //------------------------------------------------------------------------
  // Writable registers, strobes and ack
  //------------------------------------------------------------------------
  always_ff @(posedge mem_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rec_size       <= '0;
      o_play_base      <= '0;
      o_play_words     <= '0;
      o_rec_restart    <= 1'b0;
      o_play_cmd_valid <= 1'b0;
      o_ctrl_resp_ack  <= 1'b0;
    end else begin
      o_rec_restart    <= wr_hit_restart;
      o_play_cmd_valid <= wr_hit_cmd;
      o_ctrl_resp_ack  <= i_ctrl_req_wr | i_ctrl_req_rd;
      if (i_ctrl_req_wr) begin
        case (i_ctrl_req_addr)
          REG_REC_SIZE:   o_rec_size   <= size_wr;
          REG_PLAY_BASE:  o_play_base  <= i_ctrl_req_data[ADDR_W-1:0];
          REG_PLAY_WORDS: o_play_words <= i_ctrl_req_data[COUNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Readback selection, zero extended to the port width
  always_comb begin
    case (i_ctrl_req_addr)
      REG_REC_SIZE:     rd_mux = {{(REG_W-COUNT_W){1'b0}}, o_rec_size};
      REG_REC_FULLNESS: rd_mux = {{(REG_W-COUNT_W){1'b0}}, i_rec_fullness};
      REG_PLAY_BASE:    rd_mux = {{(REG_W-ADDR_W){1'b0}}, o_play_base};
      REG_PLAY_WORDS:   rd_mux = {{(REG_W-COUNT_W){1'b0}}, o_play_words};
      REG_STATUS:       rd_mux = {{(REG_W-1){1'b0}}, i_playing};
      default:          rd_mux = '0;
    endcase
  end

  // Command code and response payload
  always_ff @(posedge mem_clk) begin
    if (wr_hit_cmd) begin
      o_play_cmd <= i_ctrl_req_data[CMD_W-1:0];
    end
    o_ctrl_resp_data <= i_ctrl_req_rd ? rd_mux : '0;
  end

endmodule

// File: verilog/replay_record.sv
`timescale 1ns/1ps

/*
 * Record side. Accepts stream words while the fullness is below the record
 * size and writes each one at the fullness address in the same cycle.
 * Restart clears the fullness and wins over a transfer in the same cycle.
 */
module replay_record (
  input  logic               mem_clk,
  input  logic               i_rst_n,
  input  replay_pkg::data_t  i_in_tdata,
  input  logic               i_in_tvalid,
  input  replay_pkg::count_t i_rec_size,
  input  logic               i_rec_restart,
  output logic               o_in_tready,
  output replay_pkg::count_t o_rec_fullness,
  output logic               o_wr_en,
  output replay_pkg::addr_t  o_wr_addr,
  output replay_pkg::data_t  o_wr_data
);
  import replay_pkg::*;

  count_t fullness;
  logic   xfer;

  // Room left in the recording
  assign o_in_tready = (fullness < i_rec_size);
  assign xfer        = i_in_tvalid && o_in_tready;

  // One buffer write per accepted word
  assign o_wr_en   = xfer;
  assign o_wr_addr = fullness[ADDR_W-1:0];
  assign o_wr_data = i_in_tdata;

  always_ff @(posedge mem_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      fullness <= '0;
    end else if (i_rec_restart) begin
      fullness <= '0;
    end else if (xfer) begin
      fullness <= fullness + 1'b1;
    end
  end

  assign o_rec_fullness = fullness;

endmodule

// File: verilog/replay_ram.sv
`timescale 1ns/1ps

/*
 * Buffer memory with one write port and one registered read port.
 * A read of the address being written returns the old word.
 * Storage contents are undefined after power up.
 */
module replay_ram (
  input  logic              mem_clk,
  input  logic              i_wr_en,
  input  replay_pkg::addr_t i_wr_addr,
  input  replay_pkg::data_t i_wr_data,
  input  logic              i_rd_en,
  input  replay_pkg::addr_t i_rd_addr,
  output replay_pkg::data_t o_rd_data
);
  import replay_pkg::*;

  data_t mem [DEPTH];

  // Write port
  always_ff @(posedge mem_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read data valid the cycle after the enable
  always_ff @(posedge mem_clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

// File: verilog/replay_play.sv
`timescale 1ns/1ps

/*
 * Play side. Base and word count are captured when a play command starts.
 * Reads are issued only while the output buffer has room for them, so the
 * two-entry buffer never overflows and holds its head under back-pressure.
 * Stop ends reading; words already fetched are still delivered.
 */
module replay_play (
  input  logic                         mem_clk,
  input  logic                         i_rst_n,
  input  replay_pkg::addr_t            i_play_base,
  input  replay_pkg::count_t           i_play_words,
  input  logic                         i_play_cmd_valid,
  input  logic [replay_pkg::CMD_W-1:0] i_play_cmd,
  input  replay_pkg::data_t            i_rd_data,
  input  logic                         i_out_tready,
  output logic                         o_playing,
  output logic                         o_rd_en,
  output replay_pkg::addr_t            o_rd_addr,
  output replay_pkg::data_t            o_out_tdata,
  output logic                         o_out_tlast,
  output logic                         o_out_tvalid
);
  import replay_pkg::*;

  play_state_t state;
  count_t      offset;
  addr_t       base_q;
  count_t      words_q;
  logic        start;
  logic        pass_end;

  // Read in flight and its last-of-pass flag
  logic        rd_pend;
  logic        rd_last;

  data_t       buf_data [2];
  logic        buf_last [2];
  logic        buf_wptr;
  logic        buf_rptr;
  logic [1:0]  buf_cnt;
  logic [2:0]  fill;
  logic        pop;

  assign o_playing = (state != PLAY_IDLE);

  // Start only from idle, with a nonzero word count
  assign start = i_play_cmd_valid && (state == PLAY_IDLE) && (i_play_words != '0) &&
                 ((i_play_cmd == CMD_ONCE) || (i_play_cmd == CMD_CONT));
  assign pass_end = (offset == words_q - 1'b1);

  //------------------------------------------------------------------------
  // Read issue under the occupancy rule
  //------------------------------------------------------------------------
  assign pop  = o_out_tvalid && i_out_tready;
  assign fill = {1'b0, buf_cnt} + {2'b00, rd_pend};
  // A word leaving this cycle frees one slot
  assign o_rd_en   = o_playing && ((fill < 3'd2) || ((fill == 3'd2) && pop));
  // Wraps modulo the buffer depth
  assign o_rd_addr = base_q + offset[ADDR_W-1:0];

  always_ff @(posedge mem_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state  <= PLAY_IDLE;
      offset <= '0;
    end else begin
      case (state)
        PLAY_IDLE: begin
          offset <= '0;
          if (start) begin
            state <= (i_play_cmd == CMD_ONCE) ? PLAY_ONCE : PLAY_CONT;
          end
        end
        default: begin
          if (i_play_cmd_valid && (i_play_cmd == CMD_STOP)) begin
            state <= PLAY_IDLE;
          end else if (o_rd_en) begin
            if (pass_end) begin
              // Continuous mode wraps to the start of the region
              offset <= '0;
              if (state == PLAY_ONCE) begin
                state <= PLAY_IDLE;
              end
            end else begin
              offset <= offset + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Region captured at start
  always_ff @(posedge mem_clk) begin
    if (start) begin
      base_q  <= i_play_base;
      words_q <= i_play_words;
    end
  end

  //------------------------------------------------------------------------
  // Two-entry output buffer
  //------------------------------------------------------------------------
  always_ff @(posedge mem_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_pend  <= 1'b0;
      buf_wptr <= 1'b0;
      buf_rptr <= 1'b0;
      buf_cnt  <= '0;
    end else begin
      rd_pend <= o_rd_en;
      if (rd_pend) begin
        buf_wptr <= ~buf_wptr;
      end
      if (pop) begin
        buf_rptr <= ~buf_rptr;
      end
      buf_cnt <= buf_cnt + {1'b0, rd_pend} - {1'b0, pop};
    end
  end

  always_ff @(posedge mem_clk) begin
    if (o_rd_en) begin
      rd_last <= pass_end;
    end
    // Memory data lands one cycle after the read
    if (rd_pend) begin
      buf_data[buf_wptr] <= i_rd_data;
      buf_last[buf_wptr] <= rd_last;
    end
  end

  assign o_out_tvalid = (buf_cnt != 2'd0);
  assign o_out_tdata  = buf_data[buf_rptr];
  assign o_out_tlast  = buf_last[buf_rptr];

endmodule

// File: verilog/replay_top.sv
`timescale 1ns/1ps

/*
 * Record-and-playback block with an on-chip buffer of DEPTH words.
 * Everything runs on mem_clk. REC_SIZE is zero after reset, so the input
 * stream stalls until it is written.
 */
module replay_top (
  input  logic                  mem_clk,
  input  logic                  i_rst_n,
  input  logic                  i_ctrl_req_wr,
  input  logic                  i_ctrl_req_rd,
  input  replay_pkg::reg_addr_t i_ctrl_req_addr,
  input  replay_pkg::reg_data_t i_ctrl_req_data,
  output logic                  o_ctrl_resp_ack,
  output replay_pkg::reg_data_t o_ctrl_resp_data,
  input  replay_pkg::data_t     i_in_tdata,
  input  logic                  i_in_tvalid,
  output logic                  o_in_tready,
  output replay_pkg::data_t     o_out_tdata,
  output logic                  o_out_tlast,
  output logic                  o_out_tvalid,
  input  logic                  i_out_tready
);
  import replay_pkg::*;

  // Register file to record and play sides
  count_t           rec_size;
  logic             rec_restart;
  count_t           rec_fullness;
  addr_t            play_base;
  count_t           play_words;
  logic             play_cmd_valid;
  logic [CMD_W-1:0] play_cmd;
  logic             playing;

  // Buffer ports
  logic             wr_en;
  addr_t            wr_addr;
  data_t            wr_data;
  logic             rd_en;
  addr_t            rd_addr;
  data_t            rd_data;

  replay_regs u_regs (
    .mem_clk          (mem_clk),
    .i_rst_n          (i_rst_n),
    .i_ctrl_req_wr    (i_ctrl_req_wr),
    .i_ctrl_req_rd    (i_ctrl_req_rd),
    .i_ctrl_req_addr  (i_ctrl_req_addr),
    .i_ctrl_req_data  (i_ctrl_req_data),
    .i_rec_fullness   (rec_fullness),
    .i_playing        (playing),
    .o_ctrl_resp_ack  (o_ctrl_resp_ack),
    .o_ctrl_resp_data (o_ctrl_resp_data),
    .o_rec_size       (rec_size),
    .o_rec_restart    (rec_restart),
    .o_play_base      (play_base),
    .o_play_words     (play_words),
    .o_play_cmd_valid (play_cmd_valid),
    .o_play_cmd       (play_cmd)
  );

  replay_record u_record (
    .mem_clk        (mem_clk),
    .i_rst_n        (i_rst_n),
    .i_in_tdata     (i_in_tdata),
    .i_in_tvalid    (i_in_tvalid),
    .i_rec_size     (rec_size),
    .i_rec_restart  (rec_restart),
    .o_in_tready    (o_in_tready),
    .o_rec_fullness (rec_fullness),
    .o_wr_en        (wr_en),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data)
  );

  replay_ram u_ram (
    .mem_clk   (mem_clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  replay_play u_play (
    .mem_clk          (mem_clk),
    .i_rst_n          (i_rst_n),
    .i_play_base      (play_base),
    .i_play_words     (play_words),
    .i_play_cmd_valid (play_cmd_valid),
    .i_play_cmd       (play_cmd),
    .i_rd_data        (rd_data),
    .i_out_tready     (i_out_tready),
    .o_playing        (playing),
    .o_rd_en          (rd_en),
    .o_rd_addr        (rd_addr),
    .o_out_tdata      (o_out_tdata),
    .o_out_tlast      (o_out_tlast),
    .o_out_tvalid     (o_out_tvalid)
  );

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

/*
 * Free-running mem_clk with a 4 ns period. Reset is held low for the first
 * 5 cycles and released on a falling edge.
 */
module tb_clkgen (
  output logic o_mem_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD_NS = 2;
  localparam int RESET_CYCLES   = 5;

  initial begin
    o_mem_clk = 1'b0;
    forever #HALF_PERIOD_NS o_mem_clk = ~o_mem_clk;
  end

  // Release away from the rising edge so the async reset is clean
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_mem_clk);
    @(negedge o_mem_clk);
    o_rst_n = 1'b1;
  end

endmodule

// File: verification/replay_props.sv
`timescale 1ns/1ps

/*
 * Handshake properties of the replay block, bound into replay_top.
 * All checks are disabled while i_rst_n is low.
 */
module replay_props (
  input logic               mem_clk,
  input logic               i_rst_n,
  input logic               i_ctrl_req_wr,
  input logic               i_ctrl_req_rd,
  input logic               i_ctrl_resp_ack,
  input logic               i_in_tready,
  input replay_pkg::count_t i_rec_size,
  input replay_pkg::count_t i_rec_fullness,
  input replay_pkg::data_t  i_out_tdata,
  input logic               i_out_tlast,
  input logic               i_out_tvalid,
  input logic               i_out_tready
);

  // Output word held while the sink stalls
  out_hold: assert property (@(posedge mem_clk) disable iff (!i_rst_n)
    (i_out_tvalid && !i_out_tready) |=>
      (i_out_tvalid && $stable(i_out_tdata) && $stable(i_out_tlast)))
    else $error("output stream changed under back-pressure");

  // Every request is acked on the next cycle
  ack_follows: assert property (@(posedge mem_clk) disable iff (!i_rst_n)
    (i_ctrl_req_wr || i_ctrl_req_rd) |=> i_ctrl_resp_ack)
    else $error("register request without ack one cycle later");

  // No ack without a request one cycle before
  ack_has_req: assert property (@(posedge mem_clk) disable iff (!i_rst_n)
    i_ctrl_resp_ack |-> $past(i_ctrl_req_wr || i_ctrl_req_rd))
    else $error("register ack without a preceding request");

  // A full recording accepts nothing
  full_stalls: assert property (@(posedge mem_clk) disable iff (!i_rst_n)
    (i_rec_fullness == i_rec_size) |-> !i_in_tready)
    else $error("input ready while fullness equals record size");

endmodule

// File: verification/replay_tb.sv
`timescale 1ns/1ps

/*
 * Testbench for replay_top. Inputs change on the falling edge of mem_clk
 * and outputs are sampled there. The buffer model only knows words that
 * were recorded here, so playback regions must stay inside them.
 */
module replay_tb;
  import replay_pkg::*;

  // Tests take about 350 cycles, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  // Cycles a word is offered before it counts as refused
  localparam int OFFER_WAIT     = 8;

  logic      mem_clk;
  logic      i_rst_n;
  logic      ctrl_req_wr;
  logic      ctrl_req_rd;
  reg_addr_t ctrl_req_addr;
  reg_data_t ctrl_req_data;
  logic      ctrl_resp_ack;
  reg_data_t ctrl_resp_data;
  data_t     in_tdata;
  logic      in_tvalid;
  logic      in_tready;
  data_t     out_tdata;
  logic      out_tlast;
  logic      out_tvalid;
  logic      out_tready;

  // Buffer model and playback expectations
  data_t     model [DEPTH];
  int        rec_ptr;
  int        exp_base;
  int        exp_words;
  int        exp_limit;
  int        rx_k;
  bit        bp_enable;
  integer    seed;
  int        cycle_cnt;

  tb_clkgen u_clkgen (
    .o_mem_clk (mem_clk),
    .o_rst_n   (i_rst_n)
  );

  replay_top u_replay_top (
    .mem_clk          (mem_clk),
    .i_rst_n          (i_rst_n),
    .i_ctrl_req_wr    (ctrl_req_wr),
    .i_ctrl_req_rd    (ctrl_req_rd),
    .i_ctrl_req_addr  (ctrl_req_addr),
    .i_ctrl_req_data  (ctrl_req_data),
    .o_ctrl_resp_ack  (ctrl_resp_ack),
    .o_ctrl_resp_data (ctrl_resp_data),
    .i_in_tdata       (in_tdata),
    .i_in_tvalid      (in_tvalid),
    .o_in_tready      (in_tready),
    .o_out_tdata      (out_tdata),
    .o_out_tlast      (out_tlast),
    .o_out_tvalid     (out_tvalid),
    .i_out_tready     (out_tready)
  );

  bind replay_top replay_props u_props (
    .mem_clk         (mem_clk),
    .i_rst_n         (i_rst_n),
    .i_ctrl_req_wr   (i_ctrl_req_wr),
    .i_ctrl_req_rd   (i_ctrl_req_rd),
    .i_ctrl_resp_ack (o_ctrl_resp_ack),
    .i_in_tready     (o_in_tready),
    .i_rec_size      (rec_size),
    .i_rec_fullness  (rec_fullness),
    .i_out_tdata     (o_out_tdata),
    .i_out_tlast     (o_out_tlast),
    .i_out_tvalid    (o_out_tvalid),
    .i_out_tready    (i_out_tready)
  );

  //--------------------------------------------------------------------------
  // Reference model and checking
  //--------------------------------------------------------------------------
  // Word k of a play region, wrapping inside the region and the buffer
  function automatic data_t expected_word(input int base, input int words, input int k);
    return model[(base + (k % words)) % DEPTH];
  endfunction

  function automatic bit expected_last(input int words, input int k);
    return (k % words) == (words - 1);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string what, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0d ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp));
    end
  endtask

  //--------------------------------------------------------------------------
  // Register port and input stream drivers, entered on a falling edge
  //--------------------------------------------------------------------------
  task automatic reg_access(input bit is_wr, input reg_addr_t addr, input reg_data_t data,
                            output reg_data_t rdata);
    int waited;
    waited        = 0;
    ctrl_req_wr   = is_wr;
    ctrl_req_rd   = !is_wr;
    ctrl_req_addr = addr;
    ctrl_req_data = data;
    @(negedge mem_clk);
    ctrl_req_wr = 1'b0;
    ctrl_req_rd = 1'b0;
    while (!ctrl_resp_ack && waited < 4) begin
      @(negedge mem_clk);
      waited++;
    end
    if (!ctrl_resp_ack) begin
      abort_run($sformatf("No register ack for a request to address %0d", addr));
    end
    rdata = ctrl_resp_data;
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    reg_data_t unused_rdata;
    reg_access(1'b1, addr, data, unused_rdata);
  endtask

  task automatic reg_expect(input reg_addr_t addr, input reg_data_t exp, input string what);
    reg_data_t rdata;
    reg_access(1'b0, addr, '0, rdata);
    check_value(what, rdata, exp);
  endtask

  task automatic offer_word(input data_t word, output bit taken);
    int waited;
    waited    = 0;
    taken     = 1'b0;
    in_tdata  = word;
    in_tvalid = 1'b1;
    while (!taken && waited < OFFER_WAIT) begin
      // Ready only moves on the rising edge, so it is settled here
      if (in_tready) begin
        taken = 1'b1;
        model[rec_ptr % DEPTH] = word;
        rec_ptr++;
      end
      @(negedge mem_clk);
      waited++;
    end
    in_tvalid = 1'b0;
  endtask

  task automatic start_play(input int base, input int words, input logic [CMD_W-1:0] cmd,
                            input int limit);
    exp_base  = base;
    exp_words = words;
    exp_limit = limit;
    rx_k      = 0;
    reg_write(REG_PLAY_BASE, reg_data_t'(base));
    reg_write(REG_PLAY_WORDS, reg_data_t'(words));
    reg_write(REG_PLAY_CMD, reg_data_t'(cmd));
  endtask

  task automatic wait_words(input int n);
    while (rx_k < n) begin
      @(negedge mem_clk);
    end
  endtask

  //--------------------------------------------------------------------------
  // Output sink and compare process
  //--------------------------------------------------------------------------
  // Ready is picked first, then the word that the next rising edge takes
  always @(negedge mem_clk) begin
    out_tready = bp_enable ? (($random(seed) & 3) != 0) : 1'b1;
    if (out_tvalid && out_tready) begin
      if (rx_k >= exp_limit) begin
        abort_run("An output word arrived when no more words were expected");
      end
      check_value("out_tdata", out_tdata, expected_word(exp_base, exp_words, rx_k));
      check_value("out_tlast", reg_data_t'(out_tlast),
                  reg_data_t'(expected_last(exp_words, rx_k)));
      rx_k++;
    end
  end

  always @(posedge mem_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //--------------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------------
  initial begin
    bit taken;
    int i;
    int gap;
    int n_taken;
    seed          = 32'h74ab;
    cycle_cnt     = 0;
    rec_ptr       = 0;
    exp_base      = 0;
    exp_words     = 0;
    exp_limit     = 0;
    rx_k          = 0;
    bp_enable     = 1'b0;
    ctrl_req_wr   = 1'b0;
    ctrl_req_rd   = 1'b0;
    ctrl_req_addr = '0;
    ctrl_req_data = '0;
    in_tdata      = '0;
    in_tvalid     = 1'b0;
    out_tready    = 1'b1;
    @(posedge i_rst_n);
    @(negedge mem_clk);

    // Readback of the writable registers
    reg_expect(REG_REC_FULLNESS, 32'd0, "fullness after reset");
    reg_expect(REG_STATUS, 32'd0, "status after reset");
    reg_write(REG_REC_SIZE, 32'd37);
    reg_write(REG_PLAY_BASE, 32'h155);
    reg_write(REG_PLAY_WORDS, 32'd300);
    reg_expect(REG_REC_SIZE, 32'd37, "rec size readback");
    reg_expect(REG_PLAY_BASE, 32'h155, "play base readback");
    reg_expect(REG_PLAY_WORDS, 32'd300, "play words readback");
    reg_expect(4'hF, 32'd0, "unmapped address");

    // Record 16 of 20 offered words, with random gaps on valid
    reg_write(REG_REC_SIZE, 32'd16);
    n_taken = 0;
    for (i = 0; i < 20; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) @(negedge mem_clk);
      offer_word($random(seed), taken);
      if (taken) begin
        n_taken++;
      end else if (i < 16) begin
        abort_run($sformatf("Input word %0d refused before the record size", i));
      end
    end
    check_value("accepted words", reg_data_t'(n_taken), 32'd16);
    check_value("in_tready when full", reg_data_t'(in_tready), 32'd0);
    reg_expect(REG_REC_FULLNESS, 32'd16, "fullness after recording");

    // One pass under back-pressure
    bp_enable = 1'b1;
    start_play(4, 8, CMD_ONCE, 8);
    wait_words(8);
    repeat (6) @(negedge mem_clk);
    reg_expect(REG_STATUS, 32'd0, "status after one pass");

    // Continuous play, stopped after a few passes
    start_play(2, 5, CMD_CONT, 1 << 20);
    wait_words(12);
    reg_write(REG_PLAY_CMD, reg_data_t'(CMD_STOP));
    bp_enable = 1'b0;
    repeat (8) @(negedge mem_clk);
    n_taken = rx_k;
    repeat (8) @(negedge mem_clk);
    check_value("words after stop", reg_data_t'(rx_k), reg_data_t'(n_taken));
    check_value("out_tvalid after stop", reg_data_t'(out_tvalid), 32'd0);
    reg_expect(REG_STATUS, 32'd0, "status after stop");

    // Restart, record fresh words and play them back
    reg_write(REG_REC_RESTART, 32'd0);
    rec_ptr = 0;
    // Fullness clears on the edge after the restart pulse
    @(negedge mem_clk);
    reg_expect(REG_REC_FULLNESS, 32'd0, "fullness after restart");
    for (i = 0; i < 6; i++) begin
      offer_word($random(seed), taken);
      if (!taken) begin
        abort_run($sformatf("Input word %0d refused after restart", i));
      end
    end
    reg_expect(REG_REC_FULLNESS, 32'd6, "fullness after new recording");
    bp_enable = 1'b1;
    start_play(0, 6, CMD_ONCE, 6);
    wait_words(6);
    repeat (6) @(negedge mem_clk);
    reg_expect(REG_STATUS, 32'd0, "status after new pass");

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: sim.f
verilog/replay_pkg.sv
verilog/replay_regs.sv
verilog/replay_record.sv
verilog/replay_ram.sv
verilog/replay_play.sv
verilog/replay_top.sv
verification/tb_clkgen.sv
verification/replay_props.sv
verification/replay_tb.sv

// File: Makefile
# Verilator build and run of the replay testbench

VERILATOR ?= verilator
TOP       ?= replay_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
